//--- shift_stream_top.f
+incdir+hdl
hdl/shift_stream_pkg.sv
hdl/shift_control_fsm.sv
hdl/beat_counter.sv
hdl/shift_datapath.sv
hdl/shift_stream_top.sv
test/shift_stream_tb.sv

//--- Makefile
# Verilator lint, simulation and clean for the stream shift unit

VERILATOR ?= verilator
VFLAGS    ?= --sv --timing --assert
TOP       ?= shift_stream_tb
FILELIST  ?= shift_stream_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := TEST RESULT: FAIL

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# A crashed or aborted run is logged as a failure too
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- test/shift_stream_tb.sv
// Testbench for the stream shift unit with random stimulus, model queue and checking assertions
`default_nettype none

`include "shift_stream_settings.svh"

module shift_stream_tb;

    localparam int WORD_COUNT     = 200;
    localparam int TIMEOUT_CYCLES = WORD_COUNT * 3 * 8 + 100;

    logic                          aclk;
    logic                          aresetn;
    logic [`SHIFT_DATA_WIDTH-1:0]  s_tdata;
    logic [`SHIFT_AMT_WIDTH-1:0]   s_shift_amt;
    shift_stream_pkg::shift_op_e   s_shift_op;
    logic                          s_tvalid;
    logic                          s_tready;
    logic [`SHIFT_DATA_WIDTH-1:0]  m_tdata;
    logic                          m_tvalid;
    logic                          m_tready;
    logic                          m_tlast;

    logic                          accept;
    logic                          deliver;
    logic                          stall;

    // Model state with the queue front mirrored for the assertions
    logic [`SHIFT_DATA_WIDTH-1:0]  model_q[$];
    logic [`SHIFT_DATA_WIDTH-1:0]  exp_word = '0;
    int                            exp_count = 0;
    int                            beats_delivered = 0;

    integer                        seed;
    int                            mismatch_count;
    int                            failure_count;
    int                            words_sent;
    int                            cycle_count = 0;
    logic                          stimulus_started;

    shift_stream_top dut (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .s_tdata     (s_tdata),
        .s_shift_amt (s_shift_amt),
        .s_shift_op  (s_shift_op),
        .s_tvalid    (s_tvalid),
        .s_tready    (s_tready),
        .m_tdata     (m_tdata),
        .m_tvalid    (m_tvalid),
        .m_tready    (m_tready),
        .m_tlast     (m_tlast)
    );

    assign accept  = s_tvalid && s_tready;
    assign deliver = m_tvalid && m_tready;
    assign stall   = m_tvalid && !m_tready;

    initial begin
        aclk = 1'b0;
        forever #50 aclk = ~aclk;
    end

    // Shifts one bit position per step, straight from the opcode rules
    function automatic logic [`SHIFT_DATA_WIDTH-1:0] expected_shift(
        input logic [`SHIFT_DATA_WIDTH-1:0] data,
        input logic [`SHIFT_AMT_WIDTH-1:0]  amt,
        input shift_stream_pkg::shift_op_e  op
    );
        logic [`SHIFT_DATA_WIDTH-1:0] r;
        r = data;
        for (int i = 0; i < int'(amt); i++) begin
            case (op)
                shift_stream_pkg::OP_LSL: r = {r[`SHIFT_DATA_WIDTH-2:0], 1'b0};
                shift_stream_pkg::OP_LSR: r = {1'b0, r[`SHIFT_DATA_WIDTH-1:1]};
                shift_stream_pkg::OP_ASR: r = {r[`SHIFT_DATA_WIDTH-1], r[`SHIFT_DATA_WIDTH-1:1]};
                default:                  r = {r[0], r[`SHIFT_DATA_WIDTH-1:1]};
            endcase
        end
        return r;
    endfunction

    // Model update that sees the DUT registers from before the edge
    always @(posedge aclk) begin
        if (aresetn) begin
            if (deliver) begin
                if (model_q.size() > 0) begin
                    void'(model_q.pop_front());
                end
                beats_delivered <= beats_delivered + 1;
            end
            if (accept) begin
                model_q.push_back(expected_shift(s_tdata, s_shift_amt, s_shift_op));
            end
            exp_word  <= (model_q.size() > 0) ? model_q[0] : '0;
            exp_count <= model_q.size();
        end
    end

    always @(posedge aclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    data_check: assert property (@(posedge aclk) disable iff (!aresetn)
        deliver |-> m_tdata == exp_word)
        else begin
            mismatch_count = mismatch_count + 1;
            $display("Mismatch m_tdata: got %h expected %h",
                     $sampled(m_tdata), $sampled(exp_word));
        end

    tlast_check: assert property (@(posedge aclk) disable iff (!aresetn)
        deliver |-> m_tlast == ((beats_delivered % `SHIFT_PKT_BEATS) == `SHIFT_PKT_BEATS - 1))
        else begin
            mismatch_count = mismatch_count + 1;
            $display("Mismatch m_tlast: got %h expected %h on beat %0d", $sampled(m_tlast),
                     (($sampled(beats_delivered) % `SHIFT_PKT_BEATS) == `SHIFT_PKT_BEATS - 1),
                     $sampled(beats_delivered));
        end

    pending_check: assert property (@(posedge aclk) disable iff (!aresetn)
        deliver |-> exp_count != 0)
        else begin
            failure_count = failure_count + 1;
            $display("Delivered a word that was never accepted");
        end

    valid_delay_check: assert property (@(posedge aclk) disable iff (!aresetn)
        $past(accept, 2) |-> m_tvalid)
        else begin
            failure_count = failure_count + 1;
            $display("m_tvalid not high two edges after an accepted word");
        end

    valid_origin_check: assert property (@(posedge aclk) disable iff (!aresetn)
        $rose(m_tvalid) |-> $past(accept, 2))
        else begin
            failure_count = failure_count + 1;
            $display("m_tvalid rose without an accepted word two edges earlier");
        end

    ready_drop_check: assert property (@(posedge aclk) disable iff (!aresetn)
        $past(accept) || m_tvalid |-> !s_tready)
        else begin
            failure_count = failure_count + 1;
            $display("s_tready high while a word is still in flight");
        end

    ready_return_check: assert property (@(posedge aclk) disable iff (!aresetn)
        $past(deliver) |-> s_tready)
        else begin
            failure_count = failure_count + 1;
            $display("s_tready did not return on the edge after delivery");
        end

    ready_origin_check: assert property (@(posedge aclk) disable iff (!aresetn)
        $rose(s_tready) |-> $past(deliver))
        else begin
            failure_count = failure_count + 1;
            $display("s_tready rose without a delivery on the edge before");
        end

    // Back-pressure keeps the whole output beat frozen
    hold_check: assert property (@(posedge aclk) disable iff (!aresetn)
        $past(stall) |-> m_tvalid && $stable(m_tdata) && $stable(m_tlast))
        else begin
            failure_count = failure_count + 1;
            $display("Output beat changed or vanished while stalled");
        end

    reset_state_check: assert property (@(posedge aclk)
        !stimulus_started |-> s_tready && !m_tvalid && !m_tlast)
        else begin
            failure_count = failure_count + 1;
            $display("Outputs not in their idle state after reset");
        end

    // Advances to the next falling edge and picks the sink's ready
    task automatic next_cycle();
        logic [31:0] rnd;
        @(negedge aclk);
        rnd = $random(seed);
        m_tready = (rnd[1:0] != 2'd0);
    endtask

    // Holds the word on the input stream until the unit takes it
    task automatic send_word(
        input logic [`SHIFT_DATA_WIDTH-1:0] data,
        input logic [`SHIFT_AMT_WIDTH-1:0]  amt,
        input shift_stream_pkg::shift_op_e  op
    );
        logic taken;
        s_tdata     = data;
        s_shift_amt = amt;
        s_shift_op  = op;
        s_tvalid    = 1'b1;
        taken       = 1'b0;
        while (!taken) begin
            taken = s_tready;
            next_cycle();
        end
        s_tvalid   = 1'b0;
        words_sent = words_sent + 1;
    endtask

    initial begin
        logic [31:0] rnd;
        seed             = 19347;
        aresetn          = 1'b0;
        s_tdata          = '0;
        s_shift_amt      = '0;
        s_shift_op       = shift_stream_pkg::OP_LSL;
        s_tvalid         = 1'b0;
        m_tready         = 1'b0;
        stimulus_started = 1'b0;
        mismatch_count   = 0;
        failure_count    = 0;
        words_sent       = 0;

        repeat (16) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;
        repeat (3) next_cycle();
        stimulus_started = 1'b1;

        // Amount 0 and amount 15 for every opcode
        for (int k = 0; k < 4; k++) begin
            send_word(16'hA5C3, 4'd0, shift_stream_pkg::shift_op_e'(k[1:0]));
            send_word(16'hB00F, 4'd15, shift_stream_pkg::shift_op_e'(k[1:0]));
        end
        // Negative words for the sign fill
        send_word(16'h8001, 4'd1, shift_stream_pkg::OP_ASR);
        send_word(16'hF0F0, 4'd4, shift_stream_pkg::OP_ASR);
        send_word(16'hC000, 4'd14, shift_stream_pkg::OP_ASR);

        while (words_sent < WORD_COUNT) begin
            rnd = $random(seed);
            send_word(rnd[31:16], rnd[3:0], shift_stream_pkg::shift_op_e'(rnd[5:4]));
            if (rnd[7:6] == 2'd0) begin
                repeat (rnd[9:8]) next_cycle();
            end
        end

        // Unit back in idle with nothing on the output
        while (!s_tready || m_tvalid) begin
            next_cycle();
        end
        repeat (4) next_cycle();

        if (model_q.size() != 0) begin
            failure_count = failure_count + 1;
            $display("%0d words were accepted but never delivered", model_q.size());
        end

        $display("Words sent %0d, mismatches %0d, other failures %0d",
                 words_sent, mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/shift_stream_top.sv
// Top level of the stream shift unit joining controller, beat counter and datapath
`default_nettype none

`include "shift_stream_settings.svh"

module shift_stream_top (
    input  logic                          aclk,
    input  logic                          aresetn,

    // Input stream
    input  logic [`SHIFT_DATA_WIDTH-1:0]  s_tdata,
    input  logic [`SHIFT_AMT_WIDTH-1:0]   s_shift_amt,
    input  shift_stream_pkg::shift_op_e   s_shift_op,
    input  logic                          s_tvalid,
    output logic                          s_tready,

    // Output stream
    output logic [`SHIFT_DATA_WIDTH-1:0]  m_tdata,
    output logic                          m_tvalid,
    input  logic                          m_tready,
    output logic                          m_tlast
);

    logic load_operands;
    logic load_result;
    logic beat_done;

    shift_control_fsm u_ctrl (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .s_tvalid      (s_tvalid),
        .s_tready      (s_tready),
        .m_tready      (m_tready),
        .m_tvalid      (m_tvalid),
        .load_operands (load_operands),
        .load_result   (load_result),
        .beat_done     (beat_done)
    );

    // Counts delivered beats for tlast
    beat_counter u_beats (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .beat_done (beat_done),
        .m_tlast   (m_tlast)
    );

    shift_datapath u_datapath (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .load_operands (load_operands),
        .load_result   (load_result),
        .s_tdata       (s_tdata),
        .s_shift_amt   (s_shift_amt),
        .s_shift_op    (s_shift_op),
        .m_tdata       (m_tdata)
    );

endmodule

`default_nettype wire

//--- hdl/shift_datapath.sv
// Operand registers, four-opcode barrel shifter and result register
`default_nettype none

`include "shift_stream_settings.svh"

module shift_datapath (
    input  logic                          aclk,
    input  logic                          aresetn,
    input  logic                          load_operands,
    input  logic                          load_result,
    input  logic [`SHIFT_DATA_WIDTH-1:0]  s_tdata,
    input  logic [`SHIFT_AMT_WIDTH-1:0]   s_shift_amt,
    input  shift_stream_pkg::shift_op_e   s_shift_op,
    output logic [`SHIFT_DATA_WIDTH-1:0]  m_tdata
);

    logic [`SHIFT_DATA_WIDTH-1:0]   data_q;
    logic [`SHIFT_AMT_WIDTH-1:0]    amt_q;
    shift_stream_pkg::shift_op_e    op_q;

    logic [`SHIFT_DATA_WIDTH-1:0]   shift_result;
    logic [2*`SHIFT_DATA_WIDTH-1:0] ror_wide;

    // Operand stage
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            data_q <= '0;
            amt_q  <= '0;
            op_q   <= shift_stream_pkg::OP_LSL;
        end else if (load_operands) begin
            data_q <= s_tdata;
            amt_q  <= s_shift_amt;
            op_q   <= s_shift_op;
        end
    end

    // Rotate through a doubled word so the low bits wrap to the top
    assign ror_wide = {data_q, data_q} >> amt_q;

    always_comb begin
        shift_result = data_q;
        case (op_q)
            shift_stream_pkg::OP_LSL: begin
                shift_result = data_q << amt_q;
            end
            shift_stream_pkg::OP_LSR: begin
                shift_result = data_q >> amt_q;
            end
            shift_stream_pkg::OP_ASR: begin
                // Sign bit fills from the top
                shift_result = $signed(data_q) >>> amt_q;
            end
            shift_stream_pkg::OP_ROR: begin
                shift_result = ror_wide[`SHIFT_DATA_WIDTH-1:0];
            end
            default: begin
                shift_result = data_q;
            end
        endcase
    end

    // Result stage driving the output stream directly
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            m_tdata <= '0;
        end else if (load_result) begin
            m_tdata <= shift_result;
        end
    end

    // Output word only changes after a result load
    a_tdata_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        !load_result |=> $stable(m_tdata));

endmodule

`default_nettype wire

//--- hdl/beat_counter.sv
// Output beat counter that flags the last beat of each packet
`default_nettype none

`include "shift_stream_settings.svh"

module beat_counter (
    input  logic aclk,
    input  logic aresetn,
    input  logic beat_done,
    output logic m_tlast
);

    // One spare bit so an overrun would be visible
    localparam int CNT_W = $clog2(`SHIFT_PKT_BEATS + 1);
    localparam logic [CNT_W-1:0] LAST_BEAT = CNT_W'(`SHIFT_PKT_BEATS - 1);

    logic [CNT_W-1:0] count;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            count <= '0;
        end else if (beat_done) begin
            if (count == LAST_BEAT) begin
                count <= '0;
            end else begin
                count <= count + CNT_W'(1);
            end
        end
    end

    // Changes only on delivery, so tlast holds while the beat waits
    assign m_tlast = (count == LAST_BEAT);

    a_count_range: assert property (@(posedge aclk) disable iff (!aresetn)
        count < CNT_W'(`SHIFT_PKT_BEATS));

endmodule

`default_nettype wire

//--- hdl/shift_control_fsm.sv
// Controller FSM that accepts one word, steps it through the datapath and presents the result
`default_nettype none

module shift_control_fsm (
    input  logic aclk,
    input  logic aresetn,
    input  logic s_tvalid,
    output logic s_tready,
    input  logic m_tready,
    output logic m_tvalid,
    output logic load_operands,
    output logic load_result,
    output logic beat_done
);

    shift_stream_pkg::ctrl_state_e state;
    shift_stream_pkg::ctrl_state_e state_next;

    logic accept;
    logic deliver;

    // One word in flight, so the input opens only while idle
    assign s_tready = (state == shift_stream_pkg::ST_IDLE);
    assign m_tvalid = (state == shift_stream_pkg::ST_OUTPUT);

    assign accept  = s_tvalid && s_tready;
    assign deliver = m_tvalid && m_tready;

    assign load_operands = accept;
    assign load_result   = (state == shift_stream_pkg::ST_SHIFT);
    assign beat_done     = deliver;

    always_comb begin
        state_next = state;
        case (state)
            shift_stream_pkg::ST_IDLE: begin
                if (accept) begin
                    state_next = shift_stream_pkg::ST_SHIFT;
                end
            end
            shift_stream_pkg::ST_SHIFT: begin
                state_next = shift_stream_pkg::ST_OUTPUT;
            end
            shift_stream_pkg::ST_OUTPUT: begin
                // Result stays up until the sink takes it
                if (deliver) begin
                    state_next = shift_stream_pkg::ST_IDLE;
                end
            end
            default: begin
                state_next = shift_stream_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state <= shift_stream_pkg::ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Input and output handshakes never overlap
    a_ready_valid_excl: assert property (@(posedge aclk) disable iff (!aresetn)
        !(s_tready && m_tvalid));

    // Result capture comes exactly one cycle after operand capture
    a_load_order: assert property (@(posedge aclk) disable iff (!aresetn)
        load_operands |=> load_result);

endmodule

`default_nettype wire

//--- hdl/shift_stream_pkg.sv
// Package with the shift opcode enum and the controller state enum
`default_nettype none

package shift_stream_pkg;

    // Shift opcode carried with every input word
    typedef enum logic [1:0] {
        OP_LSL = 2'd0,
        OP_LSR = 2'd1,
        OP_ASR = 2'd2,
        OP_ROR = 2'd3
    } shift_op_e;

    // Controller states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SHIFT,
        ST_OUTPUT
    } ctrl_state_e;

endpackage

`default_nettype wire

//--- hdl/shift_stream_settings.svh
// Data width, shift amount width and packet length macros for the stream shift unit
`ifndef SHIFT_STREAM_SETTINGS_SVH
`define SHIFT_STREAM_SETTINGS_SVH

// Width of one data word on both streams
`define SHIFT_DATA_WIDTH 16

// Width of the shift amount
// Covers every amount from 0 up to the data width minus 1
`define SHIFT_AMT_WIDTH 4

// Output beats per packet
// m_tlast marks the final beat of each group of this many
`define SHIFT_PKT_BEATS 4

`endif
